// File: dv/xv_engine_tb.sv
`timescale 1ns/1ps
`include "xv_defs.svh"

module xv_engine_tb
   import xv_pkg::*;
;

   localparam int CLK_HALF = 4;
   localparam int N_ROWS = 10;
   // ten rows of about 70 cycles each, with a wide margin
   localparam int TIMEOUT_CYCLES = 3000;

   logic       rst_reg;
   logic       clk;
   axil_addr_t awaddr;
   logic       awvalid;
   logic       awready;
   axil_data_t wdata;
   logic       wvalid;
   logic       wready;
   axil_resp_t bresp;
   logic       bvalid;
   logic       bready;
   axil_addr_t araddr;
   logic       arvalid;
   logic       arready;
   axil_data_t rdata;
   axil_resp_t rresp;
   logic       rvalid;
   logic       rready;

   int cycle_count = 0;

   string      row_name [N_ROWS];
   data_t      row_c0   [N_ROWS];
   data_t      row_c1   [N_ROWS];
   axil_data_t row_mc   [N_ROWS];
   axil_data_t row_ac   [N_ROWS];
   data_t      row_mul  [N_ROWS];
   data_t      row_alu  [N_ROWS];

   xv_engine xv_engine_i (
      .rst_reg (rst_reg),
      .clk     (clk),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   initial begin
      rst_reg = 1'b0;
      forever #CLK_HALF rst_reg = ~rst_reg;
   end

   always @(posedge rst_reg) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("TESTBENCH FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act) begin
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_resp(input string name, input axil_resp_t exp,
                             input axil_resp_t act);
      if (exp !== act) begin
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1, "response mismatch");
      end
   endtask

   // host holds off the response ready for 0 to 3 cycles
   task automatic random_wait();
      int dly;
      dly = $urandom % 4;
      for (int k = 0; k < dly; k++) begin
         @(posedge rst_reg);
         #1;
      end
   endtask

   task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                             output axil_resp_t resp);
      @(posedge rst_reg);
      #1;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge rst_reg);
      while (!(awready && wready)) @(negedge rst_reg);
      @(posedge rst_reg);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      random_wait();
      bready = 1'b1;
      @(negedge rst_reg);
      while (!bvalid) @(negedge rst_reg);
      resp = bresp;
      @(posedge rst_reg);
      #1;
      bready = 1'b0;
   endtask

   task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                            output axil_resp_t resp);
      @(posedge rst_reg);
      #1;
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge rst_reg);
      while (!arready) @(negedge rst_reg);
      @(posedge rst_reg);
      #1;
      arvalid = 1'b0;
      random_wait();
      rready = 1'b1;
      @(negedge rst_reg);
      while (!rvalid) @(negedge rst_reg);
      data = rdata;
      resp = rresp;
      @(posedge rst_reg);
      #1;
      rready = 1'b0;
   endtask

   task automatic write_word(input string name, input axil_addr_t addr,
                             input axil_data_t data);
      axil_resp_t resp;
      axil_write(addr, data, resp);
      check_resp({name, " bresp"}, `XV_RESP_OKAY, resp);
   endtask

   task automatic read_and_compare(input string name, input axil_addr_t addr,
                                   input data_t exp);
      axil_data_t data;
      axil_resp_t resp;
      axil_read(addr, data, resp);
      check_resp({name, " rresp"}, `XV_RESP_OKAY, resp);
      check_data(name, exp, data);
   endtask

   task automatic set_row(input int idx, input string name, input data_t c0, input data_t c1,
                          input axil_data_t mc, input axil_data_t ac,
                          input data_t exp_mul, input data_t exp_alu);
      row_name[idx] = name;
      row_c0[idx]   = c0;
      row_c1[idx]   = c1;
      row_mc[idx]   = mc;
      row_ac[idx]   = ac;
      row_mul[idx]  = exp_mul;
      row_alu[idx]  = exp_alu;
   endtask

   initial begin
      void'($urandom(32'h4bfb_05e1));
      clk     = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;

      //      row  name          const0        const1        mul_conf      alu_conf
      //           exp mul_out   exp alu_out
      set_row(0, "mul_hi_q30",   32'h40000000, 32'h40000000, 32'h00000048, 32'h00000008,
              32'h20000000, 32'h80000000);
      set_row(1, "mul_lo_neg",   32'hFFFFFFFD, 32'h00000007, 32'h00000008, 32'h00000048,
              32'hFFFFFFEB, 32'hFFFFFFF6);
      set_row(2, "mul_div2_hi",  32'hFFFFFFFD, 32'h00000007, 32'h00000088, 32'h00000088,
              32'hFFFFFFFF, 32'h00000005);
      set_row(3, "alu_xor",      32'h12345678, 32'h00010010, 32'h00000008, 32'h00000108,
              32'h79BD6780, 32'h12355668);
      set_row(4, "alu_or",       32'h12345678, 32'h00010010, 32'h00000048, 32'h000000C8,
              32'h0000246A, 32'h12355678);
      set_row(5, "alu_max_mix",  32'h80000000, 32'h00000005, 32'h00000088, 32'h00000148,
              32'hFFFFFFFD, 32'h00000005);
      set_row(6, "alu_max_ext",  32'h7FFFFFFF, 32'h80000000, 32'h00000048, 32'h00000148,
              32'h80000001, 32'h7FFFFFFF);
      // selector 7 keeps the previous row's output
      set_row(7, "mul_disabled", 32'h00000064, 32'h00000017, 32'h0000000F, 32'h00000008,
              32'h80000001, 32'h0000007B);
      set_row(8, "alu_disabled", 32'h00000064, 32'h00000017, 32'h00000008, 32'hA5000038,
              32'h000008FC, 32'h0000007B);
      // alu adds slot 3 to const1
      set_row(9, "chain_mul_c1", 32'h00000006, 32'hFFFFFFFE, 32'h00000008, 32'h0000000B,
              32'hFFFFFFF4, 32'hFFFFFFF2);

      repeat (8) @(posedge rst_reg);
      #1;
      clk = 1'b0;

      @(negedge rst_reg);
      if (arready !== 1'b1 || awready !== 1'b0 || wready !== 1'b0 || bvalid !== 1'b0 ||
          rvalid !== 1'b0) begin
         $display("handshake outputs are wrong right after reset");
         $display("TESTBENCH FAILED");
         $fatal(1, "bad reset state");
      end
      read_and_compare("reset const0", `XV_REG_CONST0, '0);
      read_and_compare("reset const1", `XV_REG_CONST1, '0);
      read_and_compare("reset mul_conf", `XV_REG_MUL_CONF, '0);
      read_and_compare("reset alu_conf", `XV_REG_ALU_CONF, '0);
      read_and_compare("reset mul_out", `XV_REG_MUL_OUT, '0);
      read_and_compare("reset alu_out", `XV_REG_ALU_OUT, '0);

      for (int i = 0; i < N_ROWS; i++) begin
         // configs first so a disabled unit never sees the new constants
         write_word({row_name[i], " mul_conf"}, `XV_REG_MUL_CONF, row_mc[i]);
         write_word({row_name[i], " alu_conf"}, `XV_REG_ALU_CONF, row_ac[i]);
         write_word({row_name[i], " const0"}, `XV_REG_CONST0, row_c0[i]);
         write_word({row_name[i], " const1"}, `XV_REG_CONST1, row_c1[i]);
         repeat (8) @(posedge rst_reg);
         read_and_compare({row_name[i], " const0"}, `XV_REG_CONST0, row_c0[i]);
         read_and_compare({row_name[i], " const1"}, `XV_REG_CONST1, row_c1[i]);
         read_and_compare({row_name[i], " mul_conf"}, `XV_REG_MUL_CONF, row_mc[i]);
         read_and_compare({row_name[i], " alu_conf"}, `XV_REG_ALU_CONF, row_ac[i]);
         read_and_compare({row_name[i], " mul_out"}, `XV_REG_MUL_OUT, row_mul[i]);
         read_and_compare({row_name[i], " alu_out"}, `XV_REG_ALU_OUT, row_alu[i]);
      end

      // read-only and unmapped writes change nothing
      write_word("ignored mul_out", `XV_REG_MUL_OUT, 32'hDEADBEEF);
      write_word("ignored unmapped", 6'h3C, 32'h13572468);
      repeat (8) @(posedge rst_reg);
      read_and_compare("ignored mul_out", `XV_REG_MUL_OUT, row_mul[N_ROWS-1]);
      read_and_compare("ignored alu_out", `XV_REG_ALU_OUT, row_alu[N_ROWS-1]);
      read_and_compare("ignored const0", `XV_REG_CONST0, row_c0[N_ROWS-1]);
      read_and_compare("ignored alu_conf", `XV_REG_ALU_CONF, row_ac[N_ROWS-1]);
      read_and_compare("unmapped read", 6'h3C, '0);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: flist.f
+incdir+hw
hw/xv_pkg.sv
hw/xv_inmux.sv
hw/xv_mul.sv
hw/xv_alu.sv
hw/xv_axil_regs.sv
hw/xv_engine.sv
dv/xv_engine_tb.sv

// File: hw/xv_alu.sv
`timescale 1ns/1ps
`include "xv_defs.svh"

module xv_alu
   import xv_pkg::*;
(
   input  logic       rst_reg,
   input  logic       clk,
   input  flow_bus_t  flow_bus,
   input  axil_data_t conf,
   output data_t      result
);

   sel_t    sela;
   sel_t    selb;
   alu_op_t op;
   data_t   op_a;
   data_t   op_b;
   logic    en_a;
   logic    en_b;
   data_t   res;

   assign sela = conf[`XV_SELA_LSB +: `XV_N_W];
   assign selb = conf[`XV_SELB_LSB +: `XV_N_W];
   assign op   = conf[`XV_OP_LSB +: `XV_OP_W];

   xv_inmux mux_a (
      .sel      (sela),
      .flow_bus (flow_bus),
      .data_out (op_a),
      .enabled  (en_a)
   );

   xv_inmux mux_b (
      .sel      (selb),
      .flow_bus (flow_bus),
      .data_out (op_b),
      .enabled  (en_b)
   );

   // add and sub wrap at the word width
   always_comb begin
      case (op)
         `XV_ALU_ADD: res = op_a + op_b;
         `XV_ALU_SUB: res = op_a - op_b;
         `XV_ALU_AND: res = op_a & op_b;
         `XV_ALU_OR:  res = op_a | op_b;
         `XV_ALU_XOR: res = op_a ^ op_b;
         `XV_ALU_MAX: res = (op_a > op_b) ? op_a : op_b;
         default:     res = op_a + op_b;
      endcase
   end

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (en_a && en_b) begin
         result <= res;
      end
   end

endmodule

// File: hw/xv_axil_regs.sv
`timescale 1ns/1ps
`include "xv_defs.svh"

module xv_axil_regs
   import xv_pkg::*;
(
   input  logic       rst_reg,
   input  logic       clk,
   // write address and data
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  axil_data_t wdata,
   input  logic       wvalid,
   output logic       wready,
   // write response
   output axil_resp_t bresp,
   output logic       bvalid,
   input  logic       bready,
   // read address
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   // read data
   output axil_data_t rdata,
   output axil_resp_t rresp,
   output logic       rvalid,
   input  logic       rready,
   // datapath side
   output data_t      const0,
   output data_t      const1,
   output axil_data_t mul_conf,
   output axil_data_t alu_conf,
   input  data_t      mul_out,
   input  data_t      alu_out
);

   logic       wr_accept;
   logic       rd_accept;
   axil_data_t rd_word;

   // address and data must arrive together
   assign wr_accept = awvalid && wvalid && !bvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;

   assign arready   = !rvalid;
   assign rd_accept = arvalid && arready;

   assign bresp = `XV_RESP_OKAY;
   assign rresp = `XV_RESP_OKAY;

   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         const0   <= '0;
         const1   <= '0;
         mul_conf <= '0;
         alu_conf <= '0;
      end else if (wr_accept) begin
         // output and unmapped addresses fall through
         case (awaddr)
            `XV_REG_CONST0:   const0   <= wdata;
            `XV_REG_CONST1:   const1   <= wdata;
            `XV_REG_MUL_CONF: mul_conf <= wdata;
            `XV_REG_ALU_CONF: alu_conf <= wdata;
            default:          ;
         endcase
      end
   end

   // response pending flags
   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_accept) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (rd_accept) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_comb begin
      case (araddr)
         `XV_REG_CONST0:   rd_word = const0;
         `XV_REG_CONST1:   rd_word = const1;
         `XV_REG_MUL_CONF: rd_word = mul_conf;
         `XV_REG_ALU_CONF: rd_word = alu_conf;
         `XV_REG_MUL_OUT:  rd_word = mul_out;
         `XV_REG_ALU_OUT:  rd_word = alu_out;
         default:          rd_word = '0;
      endcase
   end

   // sampled once at acceptance
   always_ff @(posedge rst_reg) begin
      if (rd_accept) begin
         rdata <= rd_word;
      end
   end

endmodule

// File: hw/xv_defs.svh
`ifndef XV_DEFS_SVH
`define XV_DEFS_SVH

// datapath sizes
`define XV_DATA_W 32
`define XV_N 4
`define XV_N_W 3
`define XV_FNS_W 2
`define XV_OP_W 3
`define XV_ADDR_W 6

// config word field positions
`define XV_SELA_LSB 0
`define XV_SELB_LSB 3
`define XV_FNS_LSB 6
`define XV_OP_LSB 6

// multiplier functions
`define XV_MUL_LO 2'd0
`define XV_MUL_HI 2'd1
`define XV_MUL_DIV2_HI 2'd2

// alu ops
`define XV_ALU_ADD 3'd0
`define XV_ALU_SUB 3'd1
`define XV_ALU_AND 3'd2
`define XV_ALU_OR 3'd3
`define XV_ALU_XOR 3'd4
`define XV_ALU_MAX 3'd5

// register map, byte addresses
`define XV_REG_CONST0 6'h00
`define XV_REG_CONST1 6'h04
`define XV_REG_MUL_CONF 6'h08
`define XV_REG_ALU_CONF 6'h0C
`define XV_REG_MUL_OUT 6'h10
`define XV_REG_ALU_OUT 6'h14

// flow bus slots
`define XV_SLOT_CONST0 0
`define XV_SLOT_CONST1 1
`define XV_SLOT_ALU 2
`define XV_SLOT_MUL 3

`define XV_RESP_OKAY 2'b00

`endif

// File: hw/xv_engine.sv
`timescale 1ns/1ps
`include "xv_defs.svh"

module xv_engine
   import xv_pkg::*;
(
   input  logic       rst_reg,
   input  logic       clk,
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  axil_data_t wdata,
   input  logic       wvalid,
   output logic       wready,
   output axil_resp_t bresp,
   output logic       bvalid,
   input  logic       bready,
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output axil_data_t rdata,
   output axil_resp_t rresp,
   output logic       rvalid,
   input  logic       rready
);

   data_t      const0;
   data_t      const1;
   axil_data_t mul_conf;
   axil_data_t alu_conf;
   data_t      mul_out;
   data_t      alu_out;
   flow_bus_t  flow_bus;

   xv_axil_regs regs_i (
      .rst_reg  (rst_reg),
      .clk      (clk),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .wready   (wready),
      .bresp    (bresp),
      .bvalid   (bvalid),
      .bready   (bready),
      .araddr   (araddr),
      .arvalid  (arvalid),
      .arready  (arready),
      .rdata    (rdata),
      .rresp    (rresp),
      .rvalid   (rvalid),
      .rready   (rready),
      .const0   (const0),
      .const1   (const1),
      .mul_conf (mul_conf),
      .alu_conf (alu_conf),
      .mul_out  (mul_out),
      .alu_out  (alu_out)
   );

   // one shared bus, slot order fixed by the defs
   assign flow_bus[`XV_SLOT_CONST0*`XV_DATA_W +: `XV_DATA_W] = const0;
   assign flow_bus[`XV_SLOT_CONST1*`XV_DATA_W +: `XV_DATA_W] = const1;
   assign flow_bus[`XV_SLOT_ALU*`XV_DATA_W +: `XV_DATA_W]    = alu_out;
   assign flow_bus[`XV_SLOT_MUL*`XV_DATA_W +: `XV_DATA_W]    = mul_out;

   xv_mul mul_i (
      .rst_reg  (rst_reg),
      .clk      (clk),
      .flow_bus (flow_bus),
      .conf     (mul_conf),
      .result   (mul_out)
   );

   xv_alu alu_i (
      .rst_reg  (rst_reg),
      .clk      (clk),
      .flow_bus (flow_bus),
      .conf     (alu_conf),
      .result   (alu_out)
   );

endmodule

// File: hw/xv_inmux.sv
`timescale 1ns/1ps
`include "xv_defs.svh"

module xv_inmux
   import xv_pkg::*;
(
   input  sel_t      sel,
   input  flow_bus_t flow_bus,
   output data_t     data_out,
   output logic      enabled
);

   logic sel_valid;

   // only the low slot numbers exist on the bus
   assign sel_valid = (sel < `XV_N);

   always_comb begin
      data_out = '0;
      if (sel_valid) begin
         data_out = flow_bus[sel*`XV_DATA_W +: `XV_DATA_W];
      end
   end

   assign enabled = sel_valid;

endmodule

// File: hw/xv_mul.sv
`timescale 1ns/1ps
`include "xv_defs.svh"

module xv_mul
   import xv_pkg::*;
(
   input  logic       rst_reg,
   input  logic       clk,
   input  flow_bus_t  flow_bus,
   input  axil_data_t conf,
   output data_t      result
);

   sel_t     sela;
   sel_t     selb;
   mul_fns_t fns;
   data_t    op_a;
   data_t    op_b;
   logic     en_a;
   logic     en_b;
   data_t    op_a_reg;
   data_t    op_b_reg;
   prod_t    prod_reg;
   data_t    res_lo;
   data_t    res;

   assign sela = conf[`XV_SELA_LSB +: `XV_N_W];
   assign selb = conf[`XV_SELB_LSB +: `XV_N_W];
   assign fns  = conf[`XV_FNS_LSB +: `XV_FNS_W];

   xv_inmux mux_a (
      .sel      (sela),
      .flow_bus (flow_bus),
      .data_out (op_a),
      .enabled  (en_a)
   );

   xv_inmux mux_b (
      .sel      (selb),
      .flow_bus (flow_bus),
      .data_out (op_b),
      .enabled  (en_b)
   );

   // operand and product stages run every cycle
   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         op_a_reg <= '0;
         op_b_reg <= '0;
         prod_reg <= '0;
      end else begin
         op_a_reg <= op_a;
         op_b_reg <= op_b;
         prod_reg <= prod_t'(op_a_reg) * prod_t'(op_b_reg);
      end
   end

   assign res_lo = prod_reg[`XV_DATA_W-1:0];

   always_comb begin
      case (fns)
         `XV_MUL_LO:      res = res_lo;
         // q31 style fractional product
         `XV_MUL_HI:      res = prod_reg[2*`XV_DATA_W-2 -: `XV_DATA_W];
         `XV_MUL_DIV2_HI: res = prod_reg[2*`XV_DATA_W-1 -: `XV_DATA_W];
         default:         res = res_lo;
      endcase
   end

   // holds while a selector points at nothing
   always_ff @(posedge rst_reg or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (en_a && en_b) begin
         result <= res;
      end
   end

endmodule

// File: hw/xv_pkg.sv
`include "xv_defs.svh"

package xv_pkg;

   // one data word on the flow bus
   typedef logic signed [`XV_DATA_W-1:0] data_t;

   // full multiplier product
   typedef logic signed [2*`XV_DATA_W-1:0] prod_t;

   // slot k sits at bits 32k upward
   typedef logic [`XV_N*`XV_DATA_W-1:0] flow_bus_t;

   // 4 to 7 select nothing
   typedef logic [`XV_N_W-1:0] sel_t;

   typedef logic [`XV_FNS_W-1:0] mul_fns_t;

   typedef logic [`XV_OP_W-1:0] alu_op_t;

   // host side
   typedef logic [`XV_ADDR_W-1:0] axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0] axil_resp_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the xv_engine testbench with Verilator.
# The exit status is the simulator's; a $fatal gives a non-zero status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module xv_engine_tb -o xv_engine_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/xv_engine_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
fi
exit "$status"
